/* verilog/gmii_tx_pkg.sv */
package gmii_tx_pkg;

  ////////////////////////////////////////
  // widths and frame format
  ////////////////////////////////////////
  localparam int byte_w          = 8;      // one GMII byte
  localparam int ptr_w           = 16;     // length word
  localparam int len_w           = 11;     // byte count field of a length word
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam int preamble_len    = 7;
  localparam logic [7:0] sfd_byte      = 8'hd5;
  localparam int min_payload     = 60;     // pad target
  localparam int fcs_len         = 4;
  localparam int frame_overhead  = 12;     // preamble + sfd + fcs
  localparam int ifg_cycles      = 12;

  ////////////////////////////////////////
  // internal buffers
  ////////////////////////////////////////
  localparam int data_fifo_depth = 4096;
  localparam int ptr_fifo_depth  = 32;
  localparam int bp_threshold    = 2560;   // worst frame still fits above this

  typedef enum logic [3:0] {
    b_idle, b_preamble, b_len_load, b_first_rd, b_payload,
    b_last, b_pad_chk, b_pad, b_fcs
  } builder_state_e;

  typedef enum logic [2:0] {
    s_idle, s_len_wait, s_start, s_stream, s_gap
  } sender_state_e;

endpackage

/* verilog/crc32_8023.sv */
`timescale 1ns/1ps

module crc32_8023 (
  input  logic                            gtx_clk,
  input  logic                            rstn,
  input  logic                            crc_init_i,
  input  logic                            crc_calc_i,
  input  logic                            crc_dv_i,
  input  logic [gmii_tx_pkg::byte_w-1:0]  crc_din_i,
  output logic [gmii_tx_pkg::byte_w-1:0]  crc_dout_o
);
  import gmii_tx_pkg::*;

  logic [31:0] crc_q;

  // reflected crc-32, data bits taken lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c,
                                           input logic [byte_w-1:0] d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < byte_w; i++) begin
      fb = r[0] ^ d[i];
      r  = r >> 1;
      if (fb) r = r ^ 32'hedb8_8320;
    end
    return r;
  endfunction

  always_ff @(posedge gtx_clk or negedge rstn) begin
    if (!rstn) begin
      crc_q <= '1;
    end else if (crc_init_i) begin
      crc_q <= '1;                           // preset at frame start
    end else if (crc_calc_i) begin
      crc_q <= crc_byte(crc_q, crc_din_i);
    end else if (crc_dv_i) begin
      crc_q <= {8'hff, crc_q[31:8]};         // next fcs byte down
    end
  end

  // low-order byte goes out first
  assign crc_dout_o = ~crc_q[byte_w-1:0];

endmodule

/* verilog/frame_fifo.sv */
`timescale 1ns/1ps

module frame_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  logic                      gtx_clk,
  input  logic                      rstn,
  input  logic                      wr_en_i,
  input  logic [width-1:0]          din_i,
  input  logic                      rd_en_i,
  output logic [width-1:0]          dout_o,
  output logic                      full_o,
  output logic                      empty_o,
  output logic [$clog2(depth):0]    count_o
);

  localparam int aw = $clog2(depth);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic             wr_ok;
  logic             rd_ok;

  assign wr_ok   = wr_en_i & ~full_o;
  assign rd_ok   = rd_en_i & ~empty_o;
  assign full_o  = (count_o == depth);
  assign empty_o = (count_o == 0);

  // storage and read port, word held until the next read
  always_ff @(posedge gtx_clk) begin
    if (wr_ok) mem[wr_ptr] <= din_i;
    if (rd_ok) dout_o <= mem[rd_ptr];
  end

  always_ff @(posedge gtx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

/* verilog/frame_builder.sv */
`timescale 1ns/1ps

module frame_builder (
  input  logic                                            gtx_clk,
  input  logic                                            rstn,
  // external queues
  output logic                                            data_fifo_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]                  data_fifo_din_i,
  output logic                                            ptr_fifo_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]                   ptr_fifo_din_i,
  input  logic                                            ptr_fifo_empty_i,
  output logic                                            tdata_fifo_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]                  tdata_fifo_din_i,
  output logic                                            tptr_fifo_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]                   tptr_fifo_din_i,
  input  logic                                            tptr_fifo_empty_i,
  // internal buffers
  output logic [gmii_tx_pkg::byte_w-1:0]                  buf_din_o,
  output logic                                            dbuf_wr_o,
  output logic                                            tdbuf_wr_o,
  output logic [gmii_tx_pkg::ptr_w-1:0]                   len_din_o,
  output logic                                            lbuf_wr_o,
  output logic                                            tlbuf_wr_o,
  input  logic [$clog2(gmii_tx_pkg::data_fifo_depth):0]   dbuf_count_i,
  input  logic [$clog2(gmii_tx_pkg::data_fifo_depth):0]   tdbuf_count_i,
  input  logic                                            lbuf_full_i,
  input  logic                                            tlbuf_full_i,
  // crc unit
  output logic                                            crc_init_o,
  output logic                                            crc_calc_o,
  output logic                                            crc_dv_o,
  output logic [gmii_tx_pkg::byte_w-1:0]                  crc_din_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]                  crc_dout_i
);
  import gmii_tx_pkg::*;

  builder_state_e   state;
  logic             sel_t;       // queue being served
  logic [len_w-1:0] cnt;
  logic [len_w-1:0] len_r;
  logic [len_w-1:0] pad_cnt;
  logic             ptr_rd;
  logic             data_rd;
  logic             wr;
  logic             len_wr;
  logic             nbp;
  logic             tbp;
  logic             nrm_go;
  logic             tte_go;
  logic [byte_w-1:0] din_sel;
  logic [len_w-1:0] len_in;

  ////////////////////////////////////////
  // queue selection and back-pressure
  ////////////////////////////////////////
  assign nbp    = lbuf_full_i  | (dbuf_count_i  >= bp_threshold);
  assign tbp    = tlbuf_full_i | (tdbuf_count_i >= bp_threshold);
  assign tte_go = ~tptr_fifo_empty_i & ~tbp;
  assign nrm_go = ~ptr_fifo_empty_i  & ~nbp;

  assign din_sel = sel_t ? tdata_fifo_din_i : data_fifo_din_i;
  assign len_in  = sel_t ? tptr_fifo_din_i[len_w-1:0] : ptr_fifo_din_i[len_w-1:0];

  assign ptr_fifo_rd_o   = ptr_rd  & ~sel_t;
  assign tptr_fifo_rd_o  = ptr_rd  &  sel_t;
  assign data_fifo_rd_o  = data_rd & ~sel_t;
  assign tdata_fifo_rd_o = data_rd &  sel_t;
  assign dbuf_wr_o       = wr      & ~sel_t;
  assign tdbuf_wr_o      = wr      &  sel_t;
  assign lbuf_wr_o       = len_wr  & ~sel_t;
  assign tlbuf_wr_o      = len_wr  &  sel_t;

  assign crc_din_o = buf_din_o;                          // crc sees the written byte
  assign crc_dv_o  = (state == b_fcs) && (cnt != '0);

  ////////////////////////////////////////
  // framing FSM
  ////////////////////////////////////////
  always_ff @(posedge gtx_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= b_idle;
      sel_t      <= 1'b0;
      cnt        <= '0;
      len_r      <= '0;
      pad_cnt    <= '0;
      ptr_rd     <= 1'b0;
      data_rd    <= 1'b0;
      wr         <= 1'b0;
      len_wr     <= 1'b0;
      crc_init_o <= 1'b0;
      crc_calc_o <= 1'b0;
      buf_din_o  <= '0;
      len_din_o  <= '0;
    end else begin
      crc_init_o <= 1'b0;
      ptr_rd     <= 1'b0;
      len_wr     <= 1'b0;
      case (state)
        b_idle: begin
          // hold off while a length write is in flight since the full flag lags it
          if (!len_wr && (tte_go || nrm_go)) begin
            sel_t      <= tte_go;                        // tte has priority
            ptr_rd     <= 1'b1;
            crc_init_o <= 1'b1;
            wr         <= 1'b1;
            buf_din_o  <= preamble_byte;
            cnt        <= len_w'(preamble_len);
            state      <= b_preamble;
          end
        end
        b_preamble: begin
          if (cnt > 1) begin
            cnt <= cnt - 1'b1;
          end else begin
            buf_din_o <= sfd_byte;
            len_r     <= len_in;                         // word valid since cycle 2
            cnt       <= len_in;
            state     <= b_len_load;
          end
        end
        b_len_load: begin
          wr      <= 1'b0;
          data_rd <= 1'b1;
          pad_cnt <= (len_r < min_payload) ? len_w'(min_payload) - len_r : '0;
          state   <= b_first_rd;
        end
        b_first_rd: begin
          data_rd <= (cnt > 1);
          state   <= (cnt == 1) ? b_last : b_payload;
        end
        b_payload: begin
          wr         <= 1'b1;
          crc_calc_o <= 1'b1;
          buf_din_o  <= din_sel;
          data_rd    <= (cnt > 2);                       // exactly len reads
          cnt        <= cnt - 1'b1;
          if (cnt == 2) state <= b_last;
        end
        b_last: begin
          wr         <= 1'b1;
          crc_calc_o <= 1'b1;                            // one-byte payload skips b_payload
          buf_din_o  <= din_sel;
          state      <= b_pad_chk;
        end
        b_pad_chk: begin
          if (pad_cnt != '0) begin
            buf_din_o <= '0;
            cnt       <= pad_cnt;
            state     <= b_pad;
          end else begin
            wr         <= 1'b0;
            crc_calc_o <= 1'b0;
            cnt        <= len_w'(fcs_len);
            state      <= b_fcs;
          end
        end
        b_pad: begin
          if (cnt > 1) begin
            cnt <= cnt - 1'b1;
          end else begin
            wr         <= 1'b0;
            crc_calc_o <= 1'b0;
            cnt        <= len_w'(fcs_len);
            state      <= b_fcs;
          end
        end
        b_fcs: begin
          if (cnt != '0) begin
            wr        <= 1'b1;
            buf_din_o <= crc_dout_i;                     // crc shifts on the same edge
            cnt       <= cnt - 1'b1;
          end else begin
            wr        <= 1'b0;
            len_wr    <= 1'b1;
            len_din_o <= ptr_w'(len_r) + ptr_w'(frame_overhead) + ptr_w'(pad_cnt);
            state     <= b_idle;
          end
        end
        default: state <= b_idle;
      endcase
    end
  end

endmodule

/* verilog/gmii_sender.sv */
`timescale 1ns/1ps

module gmii_sender (
  input  logic                            gtx_clk,
  input  logic                            rstn,
  output logic                            lbuf_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]   lbuf_dout_i,
  input  logic                            lbuf_empty_i,
  output logic                            tlbuf_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]   tlbuf_dout_i,
  input  logic                            tlbuf_empty_i,
  output logic                            dbuf_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]  dbuf_dout_i,
  output logic                            tdbuf_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]  tdbuf_dout_i,
  output logic                            gtx_dv_o,
  output logic [gmii_tx_pkg::byte_w-1:0]  gm_tx_d_o
);
  import gmii_tx_pkg::*;

  sender_state_e     state;
  logic              sel_t;
  logic [len_w-1:0]  cnt;
  logic              data_rd;
  logic              rd_d;        // buffer byte valid this cycle
  logic [byte_w-1:0] byte_sel;
  logic [len_w-1:0]  len_sel;

  assign byte_sel   = sel_t ? tdbuf_dout_i : dbuf_dout_i;
  assign len_sel    = sel_t ? tlbuf_dout_i[len_w-1:0] : lbuf_dout_i[len_w-1:0];
  assign dbuf_rd_o  = data_rd & ~sel_t;
  assign tdbuf_rd_o = data_rd &  sel_t;

  always_ff @(posedge gtx_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= s_idle;
      sel_t      <= 1'b0;
      cnt        <= '0;
      data_rd    <= 1'b0;
      lbuf_rd_o  <= 1'b0;
      tlbuf_rd_o <= 1'b0;
    end else begin
      lbuf_rd_o  <= 1'b0;
      tlbuf_rd_o <= 1'b0;
      case (state)
        s_idle: begin
          if (!tlbuf_empty_i) begin
            sel_t      <= 1'b1;
            tlbuf_rd_o <= 1'b1;
            state      <= s_len_wait;
          end else if (!lbuf_empty_i) begin
            sel_t     <= 1'b0;
            lbuf_rd_o <= 1'b1;
            state     <= s_len_wait;
          end
        end
        s_len_wait: state <= s_start;                  // read latency
        s_start: begin
          cnt     <= len_sel;                          // whole frame is buffered
          data_rd <= 1'b1;
          state   <= s_stream;
        end
        s_stream: begin
          if (cnt > 1) begin
            cnt <= cnt - 1'b1;
          end else begin
            data_rd <= 1'b0;
            cnt     <= len_w'(ifg_cycles);
            state   <= s_gap;
          end
        end
        s_gap: begin
          if (cnt > 1) cnt <= cnt - 1'b1;
          else state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // GMII output register
  ////////////////////////////////////////
  always_ff @(posedge gtx_clk or negedge rstn) begin
    if (!rstn) begin
      rd_d      <= 1'b0;
      gtx_dv_o  <= 1'b0;
      gm_tx_d_o <= '0;
    end else begin
      rd_d      <= data_rd;
      gtx_dv_o  <= rd_d;
      gm_tx_d_o <= rd_d ? byte_sel : '0;             // idle bus stays at zero
    end
  end

endmodule

/* verilog/mac_t_gmii_tte.sv */
`timescale 1ns/1ps

module mac_t_gmii_tte (
  input  logic                            gtx_clk,
  input  logic                            rstn,
  output logic                            data_fifo_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]  data_fifo_din_i,
  output logic                            ptr_fifo_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]   ptr_fifo_din_i,
  input  logic                            ptr_fifo_empty_i,
  output logic                            tdata_fifo_rd_o,
  input  logic [gmii_tx_pkg::byte_w-1:0]  tdata_fifo_din_i,
  output logic                            tptr_fifo_rd_o,
  input  logic [gmii_tx_pkg::ptr_w-1:0]   tptr_fifo_din_i,
  input  logic                            tptr_fifo_empty_i,
  output logic                            gtx_dv_o,
  output logic [gmii_tx_pkg::byte_w-1:0]  gm_tx_d_o
);
  import gmii_tx_pkg::*;

  localparam int cw = $clog2(data_fifo_depth) + 1;

  logic [byte_w-1:0] buf_din;
  logic [ptr_w-1:0]  len_din;
  logic              dbuf_wr, tdbuf_wr, lbuf_wr, tlbuf_wr;
  logic              dbuf_rd, tdbuf_rd, lbuf_rd, tlbuf_rd;
  logic [byte_w-1:0] dbuf_dout, tdbuf_dout;
  logic [ptr_w-1:0]  lbuf_dout, tlbuf_dout;
  logic [cw-1:0]     dbuf_count, tdbuf_count;
  logic              lbuf_full, tlbuf_full, lbuf_empty, tlbuf_empty;
  logic              crc_init, crc_calc, crc_dv;
  logic [byte_w-1:0] crc_din, crc_dout;

  crc32_8023 u_crc32_8023 (
    .gtx_clk(gtx_clk), .rstn(rstn), .crc_init_i(crc_init), .crc_calc_i(crc_calc),
    .crc_dv_i(crc_dv), .crc_din_i(crc_din), .crc_dout_o(crc_dout)
  );

  ////////////////////////////////////////
  // per-queue frame buffers
  ////////////////////////////////////////
  frame_fifo #(.width(byte_w), .depth(data_fifo_depth)) u_dbuf (
    .gtx_clk(gtx_clk), .rstn(rstn), .wr_en_i(dbuf_wr), .din_i(buf_din),
    .rd_en_i(dbuf_rd), .dout_o(dbuf_dout), .full_o(), .empty_o(), .count_o(dbuf_count)
  );
  frame_fifo #(.width(ptr_w), .depth(ptr_fifo_depth)) u_lbuf (
    .gtx_clk(gtx_clk), .rstn(rstn), .wr_en_i(lbuf_wr), .din_i(len_din),
    .rd_en_i(lbuf_rd), .dout_o(lbuf_dout), .full_o(lbuf_full), .empty_o(lbuf_empty),
    .count_o()
  );
  frame_fifo #(.width(byte_w), .depth(data_fifo_depth)) u_tdbuf (
    .gtx_clk(gtx_clk), .rstn(rstn), .wr_en_i(tdbuf_wr), .din_i(buf_din),
    .rd_en_i(tdbuf_rd), .dout_o(tdbuf_dout), .full_o(), .empty_o(), .count_o(tdbuf_count)
  );
  frame_fifo #(.width(ptr_w), .depth(ptr_fifo_depth)) u_tlbuf (
    .gtx_clk(gtx_clk), .rstn(rstn), .wr_en_i(tlbuf_wr), .din_i(len_din),
    .rd_en_i(tlbuf_rd), .dout_o(tlbuf_dout), .full_o(tlbuf_full), .empty_o(tlbuf_empty),
    .count_o()
  );

  frame_builder u_frame_builder (
    .gtx_clk(gtx_clk), .rstn(rstn),
    .data_fifo_rd_o(data_fifo_rd_o), .data_fifo_din_i(data_fifo_din_i),
    .ptr_fifo_rd_o(ptr_fifo_rd_o), .ptr_fifo_din_i(ptr_fifo_din_i),
    .ptr_fifo_empty_i(ptr_fifo_empty_i),
    .tdata_fifo_rd_o(tdata_fifo_rd_o), .tdata_fifo_din_i(tdata_fifo_din_i),
    .tptr_fifo_rd_o(tptr_fifo_rd_o), .tptr_fifo_din_i(tptr_fifo_din_i),
    .tptr_fifo_empty_i(tptr_fifo_empty_i),
    .buf_din_o(buf_din), .dbuf_wr_o(dbuf_wr), .tdbuf_wr_o(tdbuf_wr),
    .len_din_o(len_din), .lbuf_wr_o(lbuf_wr), .tlbuf_wr_o(tlbuf_wr),
    .dbuf_count_i(dbuf_count), .tdbuf_count_i(tdbuf_count),
    .lbuf_full_i(lbuf_full), .tlbuf_full_i(tlbuf_full),
    .crc_init_o(crc_init), .crc_calc_o(crc_calc), .crc_dv_o(crc_dv),
    .crc_din_o(crc_din), .crc_dout_i(crc_dout)
  );

  gmii_sender u_gmii_sender (
    .gtx_clk(gtx_clk), .rstn(rstn),
    .lbuf_rd_o(lbuf_rd), .lbuf_dout_i(lbuf_dout), .lbuf_empty_i(lbuf_empty),
    .tlbuf_rd_o(tlbuf_rd), .tlbuf_dout_i(tlbuf_dout), .tlbuf_empty_i(tlbuf_empty),
    .dbuf_rd_o(dbuf_rd), .dbuf_dout_i(dbuf_dout),
    .tdbuf_rd_o(tdbuf_rd), .tdbuf_dout_i(tdbuf_dout),
    .gtx_dv_o(gtx_dv_o), .gm_tx_d_o(gm_tx_d_o)
  );

endmodule

/* tb/tb_mac_t_gmii_tte.sv */
`timescale 1ns/1ps

module tb_mac_t_gmii_tte;
  import gmii_tx_pkg::*;

  logic              gtx_clk = 1'b0;
  logic              rstn;
  logic              data_fifo_rd_o, ptr_fifo_rd_o, tdata_fifo_rd_o, tptr_fifo_rd_o;
  logic [byte_w-1:0] data_fifo_din_i, tdata_fifo_din_i;
  logic [ptr_w-1:0]  ptr_fifo_din_i, tptr_fifo_din_i;
  logic              ptr_fifo_empty_i, tptr_fifo_empty_i;
  logic              gtx_dv_o;
  logic [byte_w-1:0] gm_tx_d_o;

  logic [byte_w-1:0] n_bytes[$], t_bytes[$];     // external FIFO contents
  logic [ptr_w-1:0]  n_lens[$], t_lens[$];
  logic [byte_w-1:0] exp_bytes[$];               // expected frames in send order
  int                exp_lens[$];
  logic [byte_w-1:0] run_q[$];                   // current gtx_dv_o run
  int                err_count = 0;
  int                check_count = 0;
  int                frames_done = 0;
  int                gap_cnt = 0;
  bit                in_run = 1'b0;
  bit                seen_run = 1'b0;

  always #10 gtx_clk = ~gtx_clk;

  mac_t_gmii_tte u_mac_t_gmii_tte (
    .gtx_clk(gtx_clk), .rstn(rstn),
    .data_fifo_rd_o(data_fifo_rd_o), .data_fifo_din_i(data_fifo_din_i),
    .ptr_fifo_rd_o(ptr_fifo_rd_o), .ptr_fifo_din_i(ptr_fifo_din_i),
    .ptr_fifo_empty_i(ptr_fifo_empty_i),
    .tdata_fifo_rd_o(tdata_fifo_rd_o), .tdata_fifo_din_i(tdata_fifo_din_i),
    .tptr_fifo_rd_o(tptr_fifo_rd_o), .tptr_fifo_din_i(tptr_fifo_din_i),
    .tptr_fifo_empty_i(tptr_fifo_empty_i),
    .gtx_dv_o(gtx_dv_o), .gm_tx_d_o(gm_tx_d_o)
  );

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_count++;
    assert (act_v === exp_v) else begin
      err_count++;
      $display("error %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic report_underflow(input string which);
    err_count++;
    $display("read strobe at %0t while the external %s FIFO model was empty", $time, which);
  endtask

  ////////////////////////////////////////
  // external FIFO models with one cycle read latency
  ////////////////////////////////////////
  always @(posedge gtx_clk) begin
    if (ptr_fifo_rd_o) begin
      if (n_lens.size() == 0) report_underflow("normal length");
      else ptr_fifo_din_i <= n_lens.pop_front();
    end
    if (data_fifo_rd_o) begin
      if (n_bytes.size() == 0) report_underflow("normal data");
      else data_fifo_din_i <= n_bytes.pop_front();
    end
    if (tptr_fifo_rd_o) begin
      if (t_lens.size() == 0) report_underflow("TTE length");
      else tptr_fifo_din_i <= t_lens.pop_front();
    end
    if (tdata_fifo_rd_o) begin
      if (t_bytes.size() == 0) report_underflow("TTE data");
      else tdata_fifo_din_i <= t_bytes.pop_front();
    end
    ptr_fifo_empty_i  <= (n_lens.size() == 0);
    tptr_fifo_empty_i <= (t_lens.size() == 0);
  end

  // msb-first CRC-32 over bit-reversed bytes with the result reflected and inverted
  function automatic logic [31:0] ref_fcs(input logic [7:0] bytes[$]);
    logic [31:0] crc;
    logic [31:0] refl;
    logic [7:0]  rb;
    crc = 32'hffff_ffff;
    foreach (bytes[k]) begin
      for (int j = 0; j < 8; j++) begin
        rb[7-j] = bytes[k][j];
      end
      crc = crc ^ {rb, 24'h0};
      for (int j = 0; j < 8; j++) begin
        crc = crc[31] ? ((crc << 1) ^ 32'h04c1_1db7) : (crc << 1);
      end
    end
    for (int j = 0; j < 32; j++) begin
      refl[31-j] = crc[j];
    end
    return ~refl;
  endfunction

  // queue one frame in a model and append its expected bytes
  task automatic load_frame(input bit tte, input int len);
    logic [7:0]  body[$];
    logic [7:0]  b;
    logic [31:0] fcs;
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      body.push_back(b);
      if (tte) t_bytes.push_back(b);
      else n_bytes.push_back(b);
    end
    if (tte) t_lens.push_back(ptr_w'(len));
    else n_lens.push_back(ptr_w'(len));
    while (body.size() < min_payload) body.push_back(8'h00);     // zero pad
    fcs = ref_fcs(body);
    exp_lens.push_back(preamble_len + 1 + body.size() + fcs_len);
    repeat (preamble_len) exp_bytes.push_back(preamble_byte);
    exp_bytes.push_back(sfd_byte);
    foreach (body[i]) exp_bytes.push_back(body[i]);
    for (int i = 0; i < fcs_len; i++) exp_bytes.push_back(fcs[8*i +: 8]);  // low byte first
  endtask

  task automatic check_frame();
    int         exp_len;
    logic [7:0] exp_b;
    check_count++;
    assert (exp_lens.size() != 0) else begin
      err_count++;
      $display("frame of %0d bytes at %0t was not expected", run_q.size(), $time);
    end
    if (exp_lens.size() != 0) begin
      exp_len = exp_lens.pop_front();
      check_value("gtx_dv_o run length", exp_len, run_q.size());
      for (int i = 0; i < exp_len; i++) begin
        exp_b = exp_bytes.pop_front();
        if (i < run_q.size()) check_value($sformatf("gm_tx_d_o[%0d]", i), exp_b, run_q[i]);
      end
    end
    run_q = {};
    frames_done++;
  endtask

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////
  always @(posedge gtx_clk) begin
    if (rstn) begin
      if (gtx_dv_o) begin
        if (!in_run && seen_run) begin
          check_count++;
          assert (gap_cnt >= ifg_cycles) else begin
            err_count++;
            $display("error %0t gtx_dv_o low cycles expected >= %0d actual %0d",
                     $time, ifg_cycles, gap_cnt);
          end
        end
        in_run = 1'b1;
        run_q.push_back(gm_tx_d_o);
      end else if (in_run) begin
        check_frame();
        in_run   = 1'b0;
        seen_run = 1'b1;
        gap_cnt  = 1;
      end else begin
        gap_cnt++;
      end
    end
  end

  task automatic end_run();
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic wait_frames(input int target, input int max_cycles);
    int cycles;
    cycles = 0;
    while (frames_done < target && cycles < max_cycles) begin
      @(posedge gtx_clk);
      cycles++;
    end
    if (frames_done < target) begin
      err_count++;
      $display("no frame %0d on gtx_dv_o within %0d cycles", target, max_cycles);
      end_run();
    end
  endtask

  initial begin
    int unsigned seed_val;
    rstn              = 1'b0;
    data_fifo_din_i   = '0;
    tdata_fifo_din_i  = '0;
    ptr_fifo_din_i    = '0;
    tptr_fifo_din_i   = '0;
    ptr_fifo_empty_i  = 1'b1;
    tptr_fifo_empty_i = 1'b1;
    seed_val = $urandom(32'hde0b_7dd5);
    repeat (2) @(posedge gtx_clk);
    rstn <= 1'b1;

    repeat (20) begin                    // nothing queued yet
      @(posedge gtx_clk);
      check_value("gtx_dv_o", 0, gtx_dv_o);
      check_value("gm_tx_d_o", 0, gm_tx_d_o);
      check_value("data_fifo_rd_o", 0, data_fifo_rd_o);
      check_value("ptr_fifo_rd_o", 0, ptr_fifo_rd_o);
      check_value("tdata_fifo_rd_o", 0, tdata_fifo_rd_o);
      check_value("tptr_fifo_rd_o", 0, tptr_fifo_rd_o);
    end

    @(negedge gtx_clk);
    load_frame(1'b0, 60 + int'($urandom % 141));
    wait_frames(1, 2000);
    @(negedge gtx_clk);
    load_frame(1'b0, 1 + int'($urandom % 59));       // short payload gets padded
    wait_frames(2, 2000);

    // TTE expected ahead of the normal frame
    @(negedge gtx_clk);
    load_frame(1'b1, 1 + int'($urandom % 200));
    load_frame(1'b0, 1 + int'($urandom % 200));
    wait_frames(4, 3000);

    @(negedge gtx_clk);
    repeat (3) load_frame(1'b1, 1 + int'($urandom % 200));
    repeat (3) load_frame(1'b0, 1 + int'($urandom % 200));
    load_frame(1'b0, 1);                             // single payload byte
    wait_frames(11, 8000);

    repeat (200) @(posedge gtx_clk);
    check_value("frames on gtx_dv_o", 11, frames_done);
    check_value("unread external bytes", 0, n_bytes.size() + t_bytes.size());
    end_run();
  end

endmodule

/* flist.f */
verilog/gmii_tx_pkg.sv
verilog/crc32_8023.sv
verilog/frame_fifo.sv
verilog/frame_builder.sv
verilog/gmii_sender.sv
verilog/mac_t_gmii_tte.sv
tb/tb_mac_t_gmii_tte.sv
